//--- hw/rvPkg.sv
package rvPkg;

    parameter int xlen = 32;

    typedef logic [xlen-1:0] wordT;
    typedef logic [4:0]      regAddrT;
    typedef logic [2:0]      funct3T;

    // R-type layout that the other formats also read through
    typedef struct packed {
        logic [6:0] funct7;
        regAddrT    rs2;
        regAddrT    rs1;
        funct3T     funct3;
        regAddrT    rd;
        logic [6:0] opcode;
    } instrT;

    typedef enum logic [6:0] {
        load   = 7'b0000011,
        store  = 7'b0100011,
        opImm  = 7'b0010011,
        op     = 7'b0110011,
        branch = 7'b1100011
    } opcodeT;

    ////////////////////////////////////////
    // funct3 codes
    localparam funct3T f3Beq = 3'b000;
    localparam funct3T f3Bne = 3'b001;
    localparam funct3T f3Blt = 3'b100;
    localparam funct3T f3Bge = 3'b101;

    localparam funct3T f3Add = 3'b000;   // also sub
    localparam funct3T f3Sll = 3'b001;
    localparam funct3T f3Xor = 3'b100;
    localparam funct3T f3Srl = 3'b101;   // also sra
    localparam funct3T f3Or  = 3'b110;
    localparam funct3T f3And = 3'b111;

    localparam instrT nopInstr = 32'h0000_0013;  // addi x0, x0, 0

endpackage

//--- hw/pipePkg.sv
package pipePkg;

    import rvPkg::*;

    typedef enum logic [2:0] {
        add, sub, andOp, orOp, xorOp, sll, srl, sra
    } aluOpT;

    typedef enum logic [1:0] {
        fromReg, fromMem, fromWb
    } fwdSelT;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  isBranch;
        logic  aluSrcImm;
        aluOpT aluOp;
    } ctrlT;

    ////////////////////////////////////////
    // Stage payloads where all zero is a bubble
    typedef struct packed {
        wordT  pc;
        instrT instr;
    } ifIdT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    pc;
        wordT    rs1Data;
        wordT    rs2Data;
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
        wordT    imm;
        funct3T  funct3;
    } idExT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    aluResult;
        wordT    storeData;
        regAddrT rd;
    } exMemT;

    typedef struct packed {
        logic    regWrite;
        regAddrT rd;
        wordT    result;
    } memWbT;

    typedef struct packed {
        logic    valid;
        regAddrT rd;
        wordT    data;
    } retireT;

endpackage

//--- hw/stageReg.sv
module stageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clock,
    input  logic    rstN,
    input  logic    hold,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // Flush wins over hold
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

//--- hw/regFile.sv
module regFile (
    input  logic            clock,
    input  logic            rstN,
    input  rvPkg::regAddrT  rs1,
    input  rvPkg::regAddrT  rs2,
    output rvPkg::wordT     rs1Data,
    output rvPkg::wordT     rs2Data,
    input  pipePkg::memWbT  writeback
);

    import rvPkg::*;

    wordT regs [1:31];
    logic writeEn;

    assign writeEn = writeback.regWrite && (writeback.rd != '0);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeback.rd] <= writeback.result;
        end
    end

    // Same-cycle write seen by decode
    function automatic wordT readReg(regAddrT addr);
        if (addr == '0) return '0;
        if (writeEn && writeback.rd == addr) return writeback.result;
        return regs[addr];
    endfunction

    assign rs1Data = readReg(rs1);
    assign rs2Data = readReg(rs2);

endmodule

//--- hw/decodeUnit.sv
module decodeUnit (
    input  rvPkg::instrT  instr,
    output pipePkg::ctrlT ctrl,
    output rvPkg::wordT   imm
);

    import rvPkg::*;
    import pipePkg::*;

    wordT  bits;
    wordT  immI;
    wordT  immS;
    wordT  immB;
    aluOpT aluSel;
    logic  isReg;

    assign bits = instr;
    assign immI = {{20{bits[31]}}, bits[31:20]};
    assign immS = {{20{bits[31]}}, bits[31:25], bits[11:7]};
    assign immB = {{19{bits[31]}}, bits[31], bits[7], bits[30:25], bits[11:8], 1'b0};
    assign isReg = (instr.opcode == op);

    ////////////////////////////////////////
    // ALU operation
    always_comb begin
        case (instr.funct3)
            f3Add:   aluSel = (isReg && instr.funct7[5]) ? sub : add;
            f3Sll:   aluSel = sll;
            f3Xor:   aluSel = xorOp;
            f3Srl:   aluSel = instr.funct7[5] ? sra : srl;
            f3Or:    aluSel = orOp;
            f3And:   aluSel = andOp;
            default: aluSel = add;
        endcase
    end

    ////////////////////////////////////////
    // Control per opcode
    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (instr.opcode)
            op: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluSel;
            end
            opImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluSel;
                imm            = immI;
            end
            load: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                imm            = immI;
            end
            store: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                imm            = immS;
            end
            branch: begin
                ctrl.isBranch = 1'b1;
                imm           = immB;   // already byte offset
            end
            default: ctrl = '0;       // Unknown opcode gives a bubble
        endcase
    end

endmodule

//--- hw/hazardUnit.sv
module hazardUnit (
    input  rvPkg::regAddrT  rs1,
    input  rvPkg::regAddrT  rs2,
    input  pipePkg::idExT   idEx,
    input  pipePkg::exMemT  exMem,
    input  pipePkg::memWbT  memWb,
    output logic            stall,
    output pipePkg::fwdSelT fwdA,
    output pipePkg::fwdSelT fwdB
);

    import rvPkg::*;
    import pipePkg::*;

    // Load in execute feeding decode
    assign stall = idEx.ctrl.memRead && (idEx.rd != '0) &&
                   ((idEx.rd == rs1) || (idEx.rd == rs2));

    // Youngest producer first
    function automatic fwdSelT pickSource(regAddrT src);
        if (src == '0) return fromReg;
        if (exMem.ctrl.regWrite && exMem.rd == src) return fromMem;
        if (memWb.regWrite && memWb.rd == src) return fromWb;
        return fromReg;
    endfunction

    assign fwdA = pickSource(idEx.rs1);
    assign fwdB = pickSource(idEx.rs2);

endmodule

//--- hw/executeUnit.sv
module executeUnit (
    input  pipePkg::idExT   idEx,
    input  pipePkg::fwdSelT fwdA,
    input  pipePkg::fwdSelT fwdB,
    input  rvPkg::wordT     memResult,
    input  rvPkg::wordT     wbResult,
    output pipePkg::exMemT  exMem,
    output logic            branchTaken,
    output rvPkg::wordT     branchTarget
);

    import rvPkg::*;
    import pipePkg::*;

    wordT opA;
    wordT rs2Value;
    wordT opB;
    wordT aluOut;
    logic condMet;

    function automatic wordT forward(fwdSelT sel, wordT regValue);
        case (sel)
            fromMem: return memResult;
            fromWb:  return wbResult;
            default: return regValue;
        endcase
    endfunction

    assign opA      = forward(fwdA, idEx.rs1Data);
    assign rs2Value = forward(fwdB, idEx.rs2Data);
    assign opB      = idEx.ctrl.aluSrcImm ? idEx.imm : rs2Value;

    ////////////////////////////////////////
    // ALU
    always_comb begin
        case (idEx.ctrl.aluOp)
            add:     aluOut = opA + opB;
            sub:     aluOut = opA - opB;
            andOp:   aluOut = opA & opB;
            orOp:    aluOut = opA | opB;
            xorOp:   aluOut = opA ^ opB;
            sll:     aluOut = opA << opB[4:0];
            srl:     aluOut = opA >> opB[4:0];
            sra:     aluOut = wordT'($signed(opA) >>> opB[4:0]);
            default: aluOut = opA + opB;
        endcase
    end

    // Branch condition on forwarded operands
    always_comb begin
        case (idEx.funct3)
            f3Beq:   condMet = (opA == rs2Value);
            f3Bne:   condMet = (opA != rs2Value);
            f3Blt:   condMet = ($signed(opA) < $signed(rs2Value));
            f3Bge:   condMet = ($signed(opA) >= $signed(rs2Value));
            default: condMet = 1'b0;
        endcase
    end

    assign branchTaken  = idEx.ctrl.isBranch && condMet;
    assign branchTarget = idEx.pc + idEx.imm;

    assign exMem = '{ctrl: idEx.ctrl, aluResult: aluOut, storeData: rs2Value, rd: idEx.rd};

endmodule

//--- hw/dataMemory.sv
module dataMemory #(
    parameter int dataWords = 256
) (
    input  logic           clock,
    input  pipePkg::exMemT access,
    output rvPkg::wordT    readData
);

    import rvPkg::*;

    localparam int indexBits = $clog2(dataWords);

    wordT                 mem [dataWords];
    logic [indexBits-1:0] index;

    assign index = access.aluResult[indexBits+1:2];  // drop byte offset

    always_ff @(posedge clock) begin
        if (access.ctrl.memWrite) begin
            mem[index] <= access.storeData;
        end
    end

    assign readData = mem[index];

endmodule

//--- hw/pipelineCore.sv
module pipelineCore #(
    parameter rvPkg::wordT resetPc   = '0,
    parameter int          dataWords = 256
) (
    input  logic             clock,
    input  logic             rstN,
    output rvPkg::wordT      imemAddr,
    input  rvPkg::instrT     imemData,
    output pipePkg::retireT  retire
);

    import rvPkg::*;
    import pipePkg::*;

    wordT   pc;
    ifIdT   ifIdD, ifIdQ;
    idExT   idExD, idExQ;
    exMemT  exMemD, exMemQ;
    memWbT  memWbD, memWbQ;
    ctrlT   decCtrl;
    wordT   decImm;
    wordT   rs1Data, rs2Data;
    logic   stall;
    fwdSelT fwdA, fwdB;
    logic   branchTaken;
    wordT   branchTarget;
    wordT   loadData;
    wordT   memResult;

    ////////////////////////////////////////
    // Fetch
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pc + wordT'(4);
        end
    end

    assign imemAddr = pc;
    assign ifIdD    = '{pc: pc, instr: imemData};

    stageReg #(.payloadT(ifIdT)) ifIdReg (
        .clock(clock), .rstN(rstN), .hold(stall), .flush(branchTaken), .d(ifIdD), .q(ifIdQ)
    );

    ////////////////////////////////////////
    // Decode
    regFile regs (
        .clock(clock), .rstN(rstN), .rs1(ifIdQ.instr.rs1), .rs2(ifIdQ.instr.rs2),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .writeback(memWbQ)
    );

    decodeUnit decoder (.instr(ifIdQ.instr), .ctrl(decCtrl), .imm(decImm));

    hazardUnit hazards (
        .rs1(ifIdQ.instr.rs1), .rs2(ifIdQ.instr.rs2), .idEx(idExQ), .exMem(exMemQ),
        .memWb(memWbQ), .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
    );

    assign idExD = '{ctrl: decCtrl, pc: ifIdQ.pc, rs1Data: rs1Data, rs2Data: rs2Data,
                     rs1: ifIdQ.instr.rs1, rs2: ifIdQ.instr.rs2, rd: ifIdQ.instr.rd,
                     imm: decImm, funct3: ifIdQ.instr.funct3};

    // Stall inserts a bubble here
    stageReg #(.payloadT(idExT)) idExReg (
        .clock(clock), .rstN(rstN), .hold(1'b0), .flush(branchTaken || stall),
        .d(idExD), .q(idExQ)
    );

    ////////////////////////////////////////
    // Execute, memory, writeback
    executeUnit execute (
        .idEx(idExQ), .fwdA(fwdA), .fwdB(fwdB), .memResult(memResult),
        .wbResult(memWbQ.result), .exMem(exMemD), .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    stageReg #(.payloadT(exMemT)) exMemReg (
        .clock(clock), .rstN(rstN), .hold(1'b0), .flush(1'b0), .d(exMemD), .q(exMemQ)
    );

    dataMemory #(.dataWords(dataWords)) dmem (
        .clock(clock), .access(exMemQ), .readData(loadData)
    );

    assign memResult = exMemQ.ctrl.memRead ? loadData : exMemQ.aluResult;
    assign memWbD    = '{regWrite: exMemQ.ctrl.regWrite, rd: exMemQ.rd, result: memResult};

    stageReg #(.payloadT(memWbT)) memWbReg (
        .clock(clock), .rstN(rstN), .hold(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ)
    );

    assign retire = '{valid: memWbQ.regWrite && (memWbQ.rd != '0),  // x0 writes are silent
                      rd: memWbQ.rd, data: memWbQ.result};

endmodule

//--- bench/coreAsserts.sv
module coreAsserts (
    input logic            clock,
    input logic            rstN,
    input rvPkg::wordT     imemAddr,
    input pipePkg::retireT retire,
    input logic            stall
);

    retireNeedsRd: assert property (@(posedge clock) disable iff (!rstN)
        retire.valid |-> retire.rd != '0)
        else $error("retire raised for register zero");

    fetchAligned: assert property (@(posedge clock) disable iff (!rstN)
        imemAddr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    // Load-use bubble costs one cycle only
    singleStall: assert property (@(posedge clock) disable iff (!rstN)
        stall |=> !stall)
        else $error("stall held for two cycles");

    quietAfterReset: assert property (@(posedge clock) $rose(rstN) |-> !retire.valid)
        else $error("retire valid right after reset");

endmodule

bind pipelineCore coreAsserts pipelineChecks (
    .clock(clock), .rstN(rstN), .imemAddr(imemAddr), .retire(retire), .stall(stall)
);

//--- bench/coreTb.sv
module coreTb;

    import rvPkg::*;
    import pipePkg::*;

    typedef struct packed {
        regAddrT rd;
        wordT    data;
    } expectT;

    localparam int progLen        = 37;
    localparam int numRetires     = 27;
    localparam int watchdogCycles = progLen * 4 + 20;

    logic    clock;
    logic    rstN;
    wordT    imemAddr;
    instrT   imemData;
    retireT  retire;
    int      edgesSinceReset;
    int      checked;

    ////////////////////////////////////////
    // Hand-encoded program
    instrT progWords [progLen] = '{
        32'h00500093, 32'h00308113, 32'h002081B3, 32'h40118233,  // addi, addi, add, sub
        32'h003242B3, 32'h0032F333, 32'h002363B3, 32'h00439413,  // xor, and, or, slli
        32'h00245493, 32'hFF000513, 32'h401555B3, 32'h00155633,  // srli, addi -16, sra, srl
        32'h001096B3, 32'h0061F793, 32'h0307E813, 32'hFFF84893,  // sll, andi, ori, xori
        32'h00208033, 32'h00100733,                              // add x0, then read x0
        32'h04D00913, 32'h01202A23, 32'h01402983, 32'h01298A33,  // addi, sw, lw, add
        32'h00108663, 32'h7FF00A93, 32'h7FE00A93, 32'h00100B13,  // beq taken, markers
        32'h0011D663, 32'h7FF00B93, 32'h7FE00B93, 32'h00200C13,  // bge taken, markers
        32'hFFD00C93, 32'hFF900D13,                              // -3, -7
        32'h019C9663, 32'h00300D93, 32'h0190C463, 32'h00400E13,  // bne, blt not taken
        32'h01AC8EB3
    };

    // Register writes in program order
    expectT expected [numRetires] = '{
        '{5'd1,  32'h0000_0005}, '{5'd2,  32'h0000_0008}, '{5'd3,  32'h0000_000D},
        '{5'd4,  32'h0000_0008}, '{5'd5,  32'h0000_0005}, '{5'd6,  32'h0000_0005},
        '{5'd7,  32'h0000_000D}, '{5'd8,  32'h0000_00D0}, '{5'd9,  32'h0000_0034},
        '{5'd10, 32'hFFFF_FFF0}, '{5'd11, 32'hFFFF_FFFF}, '{5'd12, 32'h07FF_FFFF},
        '{5'd13, 32'h0000_00A0}, '{5'd15, 32'h0000_0004}, '{5'd16, 32'h0000_0034},
        '{5'd17, 32'hFFFF_FFCB}, '{5'd14, 32'h0000_0005}, '{5'd18, 32'h0000_004D},
        '{5'd19, 32'h0000_004D}, '{5'd20, 32'h0000_009A}, '{5'd22, 32'h0000_0001},
        '{5'd24, 32'h0000_0002}, '{5'd25, 32'hFFFF_FFFD}, '{5'd26, 32'hFFFF_FFF9},
        '{5'd27, 32'h0000_0003}, '{5'd28, 32'h0000_0004}, '{5'd29, 32'hFFFF_FFF6}
    };

    pipelineCore pipelineCore_inst (
        .clock(clock), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData), .retire(retire)
    );

    function automatic instrT fetchWord(wordT addr);
        int unsigned index;
        index = addr >> 2;
        if (index < progLen) return progWords[index];
        return nopInstr;  // past the end
    endfunction

    task automatic failRun(string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compareReg(string testName, regAddrT want, regAddrT got);
        if (got !== want) begin
            failRun($sformatf("Mismatch %s expected x%0d actual x%0d", testName, want, got));
        end
    endtask

    task automatic compareData(string testName, wordT want, wordT got);
        if (got !== want) begin
            failRun($sformatf("Mismatch %s expected %h actual %h", testName, want, got));
        end
    endtask

    ////////////////////////////////////////
    // Clock, fetch responder, watchdog
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        imemData = nopInstr;
        forever begin
            @(posedge clock);
            #1;
            imemData = fetchWord(imemAddr);
        end
    end

    always @(posedge clock) begin
        if (rstN) edgesSinceReset <= edgesSinceReset + 1;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clock);
        failRun($sformatf("Watchdog expired, only %0d of %0d retires seen", checked, numRetires));
    end

    ////////////////////////////////////////
    // Reset and retire checks
    initial begin
        rstN            = 1'b0;
        edgesSinceReset = 0;
        checked         = 0;
        repeat (2) @(posedge clock);
        #1 rstN = 1'b1;
        while (checked < numRetires) begin
            @(negedge clock);
            if (retire.valid) begin
                if (checked == 0 && edgesSinceReset < 4) begin
                    failRun("First retire came before the fourth edge after reset");
                end
                compareReg($sformatf("retire %0d rd", checked), expected[checked].rd, retire.rd);
                compareData($sformatf("retire %0d data", checked), expected[checked].data,
                            retire.data);
                checked++;
            end
        end
        $display("all tests passed");
        $finish;
    end

endmodule

//--- sources.f
hw/rvPkg.sv
hw/pipePkg.sv
hw/stageReg.sv
hw/regFile.sv
hw/decodeUnit.sv
hw/hazardUnit.sv
hw/executeUnit.sv
hw/dataMemory.sv
hw/pipelineCore.sv
bench/coreAsserts.sv
bench/coreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
